// File: hw/vec_geom_pkg.sv
`default_nettype none

// Geometry of the 64-bit vector datapath.
package vec_geom_pkg;

	localparam int XLEN      = 64;
	localparam int LANE_W    = 8;
	localparam int NUM_LANES = XLEN / LANE_W;

	// One operand or one result register.
	typedef logic [XLEN-1:0] vreg_t;

	// One bit per byte lane.
	typedef logic [NUM_LANES-1:0] lane_bits_t;

	// Per-lane difference bytes, lane 0 in the low byte.
	typedef logic [NUM_LANES-1:0][LANE_W-1:0] lane_sum_t;

endpackage

`default_nettype wire

// File: hw/vcmp_op_pkg.sv
`default_nettype none

// Control encodings and flag bundles of the comparison unit.
package vcmp_op_pkg;

	typedef enum logic [1:0]
	{
		sew_8  = 2'b00,
		sew_16 = 2'b01,
		sew_32 = 2'b10,
		sew_64 = 2'b11
	} sew_t;

	// Mixed mode is accepted but yields an empty mask.
	typedef enum logic [1:0]
	{
		sign_unsigned = 2'b00,
		sign_signed   = 2'b01,
		sign_mixed    = 2'b10
	} sign_mode_t;

	typedef enum logic [2:0]
	{
		cmp_eq = 3'd0,
		cmp_ne = 3'd1,
		cmp_lt = 3'd2,
		cmp_le = 3'd3,
		cmp_gt = 3'd4
	} cmp_op_t;

	typedef struct packed
	{
		sew_t       sew;
		sign_mode_t sign_mode;
		cmp_op_t    op;
	} cmp_ctrl_t;

	typedef struct packed
	{
		logic eq;
		logic ne;
		logic lt;
		logic le;
		logic gt;
	} cmp_flags_t;

	// Request as held in the input stage.
	typedef struct packed
	{
		cmp_ctrl_t          ctrl;
		vec_geom_pkg::vreg_t vs2;
		vec_geom_pkg::vreg_t vs1;
	} cmp_req_t;

endpackage

`default_nettype wire

// File: hw/pipe_stage.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_stage
#(
	parameter type payload_t = logic
)
(
	input  logic     clk,
	input  logic     rst_n,

	input  logic     in_valid,
	input  payload_t in_data,

	output logic     out_valid,
	output payload_t out_data
);

	// Valid bit.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	// Payload only moves with a valid beat.
	always_ff @(posedge clk)
	begin
		if (in_valid)
			out_data <= in_data;
	end

endmodule

`default_nettype wire

// File: hw/segmented_subtractor.sv
`timescale 1ns/10ps
`default_nettype none

module segmented_subtractor
(
	input  vcmp_op_pkg::sew_t         sew,

	input  vec_geom_pkg::vreg_t       vs2,
	input  vec_geom_pkg::vreg_t       vs1,

	output vec_geom_pkg::lane_sum_t   diff,
	output vec_geom_pkg::lane_bits_t  carry
);

	import vec_geom_pkg::*;
	import vcmp_op_pkg::*;

	lane_bits_t elem_start;	// Lanes that open a new element.
	lane_bits_t carry_in;

	// Element boundaries per width.
	always_comb
	begin
		case (sew)
			sew_8  : elem_start = 8'b1111_1111;
			sew_16 : elem_start = 8'b0101_0101;
			sew_32 : elem_start = 8'b0001_0001;
			sew_64 : elem_start = 8'b0000_0001;
			default: elem_start = 8'b0000_0001;
		endcase
	end

	// Ripple through the lanes, restarting at each element.
	always_comb
	begin : ripple
		logic [LANE_W:0]   lane_res;
		logic [LANE_W-1:0] a_byte;
		logic [LANE_W-1:0] b_byte;
		logic              c;

		c = 1'b1;
		for (int i = 0; i < NUM_LANES; i++)
		begin
			if (elem_start[i])
				c = 1'b1;	// vs2 + ~vs1 + 1.
			carry_in[i] = c;

			a_byte = vs2[i*LANE_W +: LANE_W];
			b_byte = ~vs1[i*LANE_W +: LANE_W];

			lane_res = {1'b0, a_byte}
				+ {1'b0, b_byte}
				+ {{LANE_W{1'b0}}, carry_in[i]};

			diff[i]  = lane_res[LANE_W-1:0];
			carry[i] = lane_res[LANE_W];	// One means no borrow.
			c        = carry[i];
		end
	end

endmodule

`default_nettype wire

// File: hw/element_flag_gen.sv
`timescale 1ns/10ps
`default_nettype none

module element_flag_gen
(
	input  vcmp_op_pkg::sign_mode_t  sign_mode,

	input  vec_geom_pkg::lane_sum_t  diff,
	input  vec_geom_pkg::lane_bits_t carry,
	input  vec_geom_pkg::vreg_t      vs2,
	input  vec_geom_pkg::vreg_t      vs1,

	output vcmp_op_pkg::cmp_flags_t [vec_geom_pkg::NUM_LANES-1:0]   flags_8,
	output vcmp_op_pkg::cmp_flags_t [vec_geom_pkg::NUM_LANES/2-1:0] flags_16,
	output vcmp_op_pkg::cmp_flags_t [vec_geom_pkg::NUM_LANES/4-1:0] flags_32,
	output vcmp_op_pkg::cmp_flags_t [vec_geom_pkg::NUM_LANES/8-1:0] flags_64
);

	import vec_geom_pkg::*;
	import vcmp_op_pkg::*;

	lane_bits_t lane_zero;	// Difference byte is zero.
	lane_bits_t lane_lt_u;
	lane_bits_t lane_lt_s;
	lane_bits_t lane_lt;
	logic       mode_ok;

	// Full flag set from eq and lt.
	function automatic cmp_flags_t make_flags(input logic eq, input logic lt, input logic en);
		cmp_flags_t f;

		f.eq = eq;
		f.ne = ~eq;
		f.lt = lt;
		f.le = lt | eq;
		f.gt = ~(lt | eq);
		return en ? f : '0;
	endfunction

	assign mode_ok = (sign_mode == sign_unsigned) || (sign_mode == sign_signed);

	// Per-lane terms, valid when the lane is the top of its element.
	always_comb
	begin
		logic a_sign;
		logic b_sign;
		logic d_sign;

		for (int i = 0; i < NUM_LANES; i++)
		begin
			a_sign = vs2[i*LANE_W + LANE_W-1];
			b_sign = ~vs1[i*LANE_W + LANE_W-1];
			d_sign = diff[i][LANE_W-1];

			lane_zero[i] = (diff[i] == '0);
			lane_lt_u[i] = ~carry[i];

			// Difference sign corrected by overflow.
			lane_lt_s[i] = d_sign ^ (~(a_sign ^ b_sign) & (d_sign ^ b_sign));
		end
	end

	assign lane_lt = (sign_mode == sign_signed) ? lane_lt_s : lane_lt_u;

	// Byte elements.
	always_comb
	begin
		for (int i = 0; i < NUM_LANES; i++)
			flags_8[i] = make_flags(lane_zero[i], lane_lt[i], mode_ok);
	end

	always_comb
	begin
		for (int i = 0; i < NUM_LANES/2; i++)
			flags_16[i] = make_flags(&lane_zero[2*i +: 2], lane_lt[2*i+1], mode_ok);
	end

	always_comb
	begin
		for (int i = 0; i < NUM_LANES/4; i++)
			flags_32[i] = make_flags(&lane_zero[4*i +: 4], lane_lt[4*i+3], mode_ok);
	end

	// Whole word.
	always_comb
	begin
		for (int i = 0; i < NUM_LANES/8; i++)
			flags_64[i] = make_flags(&lane_zero[8*i +: 8], lane_lt[8*i+7], mode_ok);
	end

endmodule

`default_nettype wire

// File: hw/mask_select.sv
`timescale 1ns/10ps
`default_nettype none

module mask_select
(
	input  vcmp_op_pkg::sew_t        sew,
	input  vcmp_op_pkg::cmp_op_t     op,

	input  vcmp_op_pkg::cmp_flags_t [vec_geom_pkg::NUM_LANES-1:0]   flags_8,
	input  vcmp_op_pkg::cmp_flags_t [vec_geom_pkg::NUM_LANES/2-1:0] flags_16,
	input  vcmp_op_pkg::cmp_flags_t [vec_geom_pkg::NUM_LANES/4-1:0] flags_32,
	input  vcmp_op_pkg::cmp_flags_t [vec_geom_pkg::NUM_LANES/8-1:0] flags_64,

	output vec_geom_pkg::lane_bits_t mask
);

	import vec_geom_pkg::*;
	import vcmp_op_pkg::*;

	// One flag out of the set.
	function automatic logic pick(input cmp_flags_t f, input cmp_op_t op_sel);
		case (op_sel)
			cmp_eq : return f.eq;
			cmp_ne : return f.ne;
			cmp_lt : return f.lt;
			cmp_le : return f.le;
			cmp_gt : return f.gt;
			default: return 1'b0;	// Unknown op.
		endcase
	endfunction

	always_comb
	begin
		mask = '0;	// Bits above the element count stay clear.

		case (sew)
			sew_8 :
				for (int i = 0; i < NUM_LANES; i++)
					mask[i] = pick(flags_8[i], op);

			sew_16 :
				for (int i = 0; i < NUM_LANES/2; i++)
					mask[i] = pick(flags_16[i], op);

			sew_32 :
				for (int i = 0; i < NUM_LANES/4; i++)
					mask[i] = pick(flags_32[i], op);

			sew_64 :
				for (int i = 0; i < NUM_LANES/8; i++)
					mask[i] = pick(flags_64[i], op);

			default :
				mask = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/vector_comparison_unit.sv
`timescale 1ns/10ps
`default_nettype none

module vector_comparison_unit
(
	input  logic                    clk,
	input  logic                    rst_n,

	input  logic                    in_valid,
	input  vcmp_op_pkg::cmp_ctrl_t  in_ctrl,
	input  vec_geom_pkg::vreg_t     vs2,
	input  vec_geom_pkg::vreg_t     vs1,

	output logic                    out_valid,
	output vec_geom_pkg::vreg_t     vd
);

	import vec_geom_pkg::*;
	import vcmp_op_pkg::*;

	cmp_req_t   req_in;
	cmp_req_t   req_q;
	logic       req_valid;

	lane_sum_t  diff;
	lane_bits_t carry;

	cmp_flags_t [NUM_LANES-1:0]   flags_8;
	cmp_flags_t [NUM_LANES/2-1:0] flags_16;
	cmp_flags_t [NUM_LANES/4-1:0] flags_32;
	cmp_flags_t [NUM_LANES/8-1:0] flags_64;

	lane_bits_t mask;
	vreg_t      result;

	assign req_in = '{ctrl: in_ctrl, vs2: vs2, vs1: vs1};

	// Input register.
	pipe_stage #(.payload_t(cmp_req_t)) u_req_stage
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_data   (req_in),
		.out_valid (req_valid),
		.out_data  (req_q)
	);

	segmented_subtractor u_sub
	(
		.sew   (req_q.ctrl.sew),
		.vs2   (req_q.vs2),
		.vs1   (req_q.vs1),
		.diff  (diff),
		.carry (carry)
	);

	element_flag_gen u_flags
	(
		.sign_mode (req_q.ctrl.sign_mode),
		.diff      (diff),
		.carry     (carry),
		.vs2       (req_q.vs2),
		.vs1       (req_q.vs1),
		.flags_8   (flags_8),
		.flags_16  (flags_16),
		.flags_32  (flags_32),
		.flags_64  (flags_64)
	);

	mask_select u_mask
	(
		.sew      (req_q.ctrl.sew),
		.op       (req_q.ctrl.op),
		.flags_8  (flags_8),
		.flags_16 (flags_16),
		.flags_32 (flags_32),
		.flags_64 (flags_64),
		.mask     (mask)
	);

	assign result = {{(XLEN-NUM_LANES){1'b0}}, mask};	// Mask sits in the low bits.

	// Output register.
	pipe_stage #(.payload_t(vreg_t)) u_res_stage
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (req_valid),
		.in_data   (result),
		.out_valid (out_valid),
		.out_data  (vd)
	);

endmodule

`default_nettype wire

// File: tb/vcmp_ref.svh
`ifndef VCMP_REF_SVH
`define VCMP_REF_SVH

// Expected vd for one request, element by element.
function automatic vreg_t ref_vcmp(input cmp_ctrl_t ctrl, input vreg_t a_vec, input vreg_t b_vec);
	vreg_t       res;
	int          w;
	int          n;
	logic [63:0] ea;
	logic [63:0] eb;
	longint      sa;
	longint      sb;
	logic        lt;
	logic        eq;
	logic        bit_r;

	res = '0;
	w   = 8 << int'(ctrl.sew);
	n   = 64 / w;

	if (ctrl.sign_mode != sign_unsigned && ctrl.sign_mode != sign_signed)
		return '0;

	for (int i = 0; i < n; i++)
	begin
		ea = a_vec >> (i * w);
		eb = b_vec >> (i * w);
		if (w < 64)
		begin
			ea = ea & ((64'd1 << w) - 64'd1);
			eb = eb & ((64'd1 << w) - 64'd1);
		end

		// Sign extend from the element width.
		sa = $signed(ea << (64 - w)) >>> (64 - w);
		sb = $signed(eb << (64 - w)) >>> (64 - w);

		eq = (ea == eb);
		lt = (ctrl.sign_mode == sign_signed) ? (sa < sb) : (ea < eb);

		case (ctrl.op)
			cmp_eq : bit_r = eq;
			cmp_ne : bit_r = !eq;
			cmp_lt : bit_r = lt;
			cmp_le : bit_r = lt || eq;
			cmp_gt : bit_r = !(lt || eq);
			default: bit_r = 1'b0;
		endcase

		res[i] = bit_r;
	end

	return res;
endfunction

`endif

// File: tb/tb_vector_comparison_unit.sv
`timescale 1ns/10ps
`default_nettype none

module tb_vector_comparison_unit;

	import vec_geom_pkg::*;
	import vcmp_op_pkg::*;

	`include "vcmp_ref.svh"

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_DIRECTED = 288;
	localparam int NUM_RANDOM   = 300;
	localparam int TEST_COUNT   = 2 * NUM_DIRECTED + NUM_RANDOM;	// Gaps included.
	localparam int SEED         = 32'hbdea2f70;

	logic      clk;
	logic      rst_n;
	logic      in_valid;
	cmp_ctrl_t in_ctrl;
	vreg_t     vs2;
	vreg_t     vs1;
	logic      out_valid;
	vreg_t     vd;

	int          seed;
	int          value_errs;
	int          protocol_errs;
	int unsigned cycle_cnt;

	vreg_t       exp_vd_q[$];
	cmp_ctrl_t   exp_ctrl_q[$];
	int unsigned due_q[$];

	vector_comparison_unit uut
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ctrl   (in_ctrl),
		.vs2       (vs2),
		.vs1       (vs1),
		.out_valid (out_valid),
		.vd        (vd)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic vreg_t rand_word();
		return {$random(seed), $random(seed)};
	endfunction

	// Top bit of every element set.
	function automatic vreg_t element_top_bits(input int s);
		vreg_t r;
		int    w;

		r = '0;
		w = 8 << s;
		for (int i = 0; i < 64 / w; i++)
			r[i*w + w-1] = 1'b1;
		return r;
	endfunction

	function automatic cmp_ctrl_t make_ctrl(input int s, input int m, input int o);
		return cmp_ctrl_t'({2'(s), 2'(m), 3'(o)});
	endfunction

	task automatic drive_request(input cmp_ctrl_t ctrl, input vreg_t a, input vreg_t b);
		@(negedge clk);
		in_valid = 1'b1;
		in_ctrl  = ctrl;
		vs2      = a;
		vs1      = b;
		exp_vd_q.push_back(ref_vcmp(ctrl, a, b));
		exp_ctrl_q.push_back(ctrl);
		due_q.push_back(cycle_cnt + 2);	// Accepted next edge and out two later.
	endtask

	// Garbage on the operands while in_valid is low.
	task automatic idle_cycle();
		@(negedge clk);
		in_valid = 1'b0;
		vs2      = rand_word();
		vs1      = rand_word();
	endtask

	task automatic maybe_gap();
		if ($random(seed) & 1)
			idle_cycle();
	endtask

	// Scoreboard.
	always @(posedge clk)
	begin : compare
		vreg_t       exp_vd;
		cmp_ctrl_t   exp_ctrl;
		int unsigned due;

		if (rst_n)
		begin
			if (out_valid !== 1'b0 && out_valid !== 1'b1)
			begin
				$display("ERROR: out_valid is unknown at %0d ns", $time);
				protocol_errs++;
			end
			else if (out_valid)
			begin
				if (exp_vd_q.size() == 0)
				begin
					$display("ERROR: out_valid high at %0d ns with no request outstanding", $time);
					protocol_errs++;
				end
				else
				begin
					exp_vd   = exp_vd_q.pop_front();
					exp_ctrl = exp_ctrl_q.pop_front();
					due      = due_q.pop_front();
					if (cycle_cnt != due)
					begin
						$display("ERROR: result due at cycle %0d arrived at cycle %0d",
							due, cycle_cnt);
						protocol_errs++;
					end
					if (vd !== exp_vd)
					begin
						$display("[FAIL] %0d ns: sew=%0d mode=%0d op=%0d expected vd %h, got %h",
							$time, exp_ctrl.sew, exp_ctrl.sign_mode, exp_ctrl.op, exp_vd, vd);
						value_errs++;
					end
				end
			end
		end
		cycle_cnt++;
	end

	initial
	begin
		#((TEST_COUNT + 50) * CLK_PERIOD);
		$display("ERROR: timeout, run did not finish within %0d ns",
			(TEST_COUNT + 50) * CLK_PERIOD);
		$display("Testbench failed");
		$finish;
	end

	initial
	begin
		vreg_t a;
		vreg_t b;
		vreg_t r;
		vreg_t top;
		vreg_t sel;
		int    pos;

		seed          = SEED;
		value_errs    = 0;
		protocol_errs = 0;
		cycle_cnt     = 0;
		rst_n         = 1'b0;
		in_valid      = 1'b0;
		in_ctrl       = '0;
		vs2           = '0;
		vs1           = '0;

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		repeat (3) idle_cycle();	// No output expected here.

		// Equal operands then one differing byte.
		for (int s = 0; s < 4; s++)
			for (int o = 0; o < 2; o++)
				for (int k = 0; k < 4; k++)
				begin
					a = rand_word();
					b = a;
					if (k != 0)
					begin
						pos = {$random(seed)} % 8;
						b   = a ^ (vreg_t'({$random(seed)} % 255 + 1) << (8 * pos));
					end
					drive_request(make_ctrl(s, k % 2, o), a, b);
					maybe_gap();
				end

		// Ordering corners for unsigned then signed.
		for (int m = 0; m < 2; m++)
			for (int s = 0; s < 4; s++)
				for (int o = 2; o < 5; o++)
					for (int k = 0; k < 7; k++)
					begin
						top = element_top_bits(s);
						r   = rand_word();
						case (k)
							0:       a = '0;
							1:       a = '1;
							2, 3:    a = r;
							4:       a = r ^ top;
							5:       a = top;
							default: a = ~top;
						endcase
						case (k)
							0:       b = '1;
							1:       b = '0;
							2, 4:    b = r;
							3:       b = r ^ top;
							5:       b = ~top;
							default: b = top;
						endcase
						drive_request(make_ctrl(s, m, o), a, b);
						maybe_gap();
					end

		// Mixed sign mode and unknown op codes.
		for (int s = 0; s < 4; s++)
			for (int m = 0; m < 4; m++)
				for (int o = 0; o < 8; o++)
					if (m >= 2 || o >= 5)
					begin
						drive_request(make_ctrl(s, m, o), rand_word(), rand_word());
						maybe_gap();
					end

		// Back to back with some bytes shared so eq fires.
		for (int t = 0; t < NUM_RANDOM; t++)
		begin
			a   = rand_word();
			sel = rand_word();
			b   = (rand_word() & sel) | (a & ~sel);
			drive_request(cmp_ctrl_t'(7'($random(seed))), a, b);
		end

		idle_cycle();
		for (int i = 0; i < 8 && exp_vd_q.size() != 0; i++)
			@(negedge clk);
		repeat (4) idle_cycle();

		if (exp_vd_q.size() != 0)
		begin
			$display("ERROR: %0d requests never returned a result", exp_vd_q.size());
			protocol_errs++;
		end

		$display("Errors: %0d value mismatches, %0d protocol errors", value_errs, protocol_errs);
		if (value_errs == 0 && protocol_errs == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+tb
hw/vec_geom_pkg.sv
hw/vcmp_op_pkg.sv
hw/pipe_stage.sv
hw/segmented_subtractor.sv
hw/element_flag_gen.sv
hw/mask_select.sv
hw/vector_comparison_unit.sv
tb/tb_vector_comparison_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the comparison unit testbench with Verilator.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing \
	-f compile.f \
	--top-module tb_vector_comparison_unit \
	-o vtb

./obj_dir/vtb | tee "$LOG"

if grep -q "^Testbench passed$" "$LOG"; then
	echo "Simulation passed."
	exit 0
else
	echo "Simulation failed, see $LOG."
	exit 1
fi
